//--- filelist.f
+incdir+hdl
hdl/fp_mul_pkg.sv
hdl/fp_operand_if.sv
hdl/fp_unpack.sv
hdl/booth_radix4_mul.sv
hdl/fp_round_norm.sv
hdl/fp_mul.sv
verif/fp_mul_assert.sv
verif/fp_mul_tb.sv

//--- hdl/booth_radix4_mul.sv
`include "fp_mul_defines.svh"

module booth_radix4_mul import fp_mul_pkg::*; (
    input  logic                  clk,
    input  logic                  inValid,
    input  logic [`FP_FRAC_W-1:0] fracX,
    input  logic [`FP_FRAC_W-1:0] fracY,
    output logic [`FP_PROD_W-1:0] prodFull
);

    localparam int NumDigits = `FP_SIG_W / 2;

    logic [`FP_SIG_W-1:0]  sigX;
    // Multiplier with an implicit zero below its LSB
    logic [`FP_SIG_W:0]    recodeY;
    logic [`FP_PROD_W-1:0] sigXExt;
    boothDigitE            digit [NumDigits];
    logic [`FP_PROD_W-1:0] partProd [NumDigits];
    logic [`FP_PROD_W-1:0] prodSum;

    assign sigX    = {1'b1, fracX};
    assign recodeY = {1'b1, fracY, 1'b0};
    assign sigXExt = {{(`FP_PROD_W - `FP_SIG_W){1'b0}}, sigX};

    // Recode overlapping triplets of the multiplier
    always_comb begin
        for (int i = 0; i < NumDigits; i++) begin
            case (recodeY[2*i +: 3])
                3'b001, 3'b010: digit[i] = BD_POS1;
                3'b011:         digit[i] = BD_POS2;
                3'b100:         digit[i] = BD_NEG2;
                3'b101, 3'b110: digit[i] = BD_NEG1;
                default:        digit[i] = BD_ZERO;
            endcase
        end
    end

    // Partial products in two's complement over the full product width
    always_comb begin
        for (int i = 0; i < NumDigits; i++) begin
            case (digit[i])
                BD_POS1: partProd[i] = sigXExt;
                BD_POS2: partProd[i] = sigXExt << 1;
                BD_NEG1: partProd[i] = -sigXExt;
                BD_NEG2: partProd[i] = -(sigXExt << 1);
                default: partProd[i] = '0;
            endcase
        end
    end

    always_comb begin
        // The top digit reads the hidden one as a sign bit
        // so one copy of sigX weighted 2^24 restores the unsigned product
        prodSum = sigXExt << `FP_SIG_W;
        for (int i = 0; i < NumDigits; i++) begin
            prodSum = prodSum + (partProd[i] << (2 * i));
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            prodFull <= prodSum;
        end
    end

endmodule

//--- hdl/fp_mul.sv
`include "fp_mul_defines.svh"

module fp_mul import fp_mul_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inValid,
    input  logic [`FP_WORD_W-1:0] fpX,
    input  logic [`FP_WORD_W-1:0] fpY,
    input  roundModeE             rMode,
    output logic                  outValid,
    output logic [`FP_WORD_W-1:0] fpZ,
    output logic                  ovrf,
    output logic                  udrf
);

    logic [`FP_PROD_W-1:0] prodFull;

    // Stage 1 to stage 2 operand bundle
    fpOperandIf opndBus ();

    // Stage 1, operand fields and classes
    fp_unpack unpack_i (
        .clk     (clk),
        .rst     (rst),
        .inValid (inValid),
        .fpX     (fpX),
        .fpY     (fpY),
        .rMode   (rMode),
        .opnd    (opndBus.producer)
    );

    // Stage 1, significand product
    booth_radix4_mul mul_i (
        .clk      (clk),
        .inValid  (inValid),
        .fracX    (fpX[`FP_FRAC_W-1:0]),
        .fracY    (fpY[`FP_FRAC_W-1:0]),
        .prodFull (prodFull)
    );

    // Stage 2, normalize, round and pack
    fp_round_norm round_i (
        .clk      (clk),
        .rst      (rst),
        .opnd     (opndBus.consumer),
        .prodFull (prodFull),
        .outValid (outValid),
        .fpZ      (fpZ),
        .ovrf     (ovrf),
        .udrf     (udrf)
    );

endmodule

//--- hdl/fp_mul_defines.svh
`ifndef FP_MUL_DEFINES_SVH
`define FP_MUL_DEFINES_SVH

// Binary32 word layout
`define FP_WORD_W 32
`define FP_EXP_W 8
`define FP_FRAC_W 23

// Significand including the hidden one
`define FP_SIG_W (`FP_FRAC_W + 1)

// Full width of the significand product
`define FP_PROD_W 48

// Exponent bias
`define FP_BIAS 127

// Canonical quiet NaN returned for every invalid product
`define FP_QNAN 32'h7FC00000

`endif

//--- hdl/fp_mul_pkg.sv
package fp_mul_pkg;

    // Rounding modes carried on rMode, codes 5 to 7 fall back to RNE
    typedef enum logic [2:0] {
        RNE = 3'd0,  // Nearest, ties to even
        RTZ = 3'd1,  // Toward zero
        RDN = 3'd2,  // Toward minus infinity
        RUP = 3'd3,  // Toward plus infinity
        RMM = 3'd4   // Nearest, ties away from zero
    } roundModeE;

    // Operand class after unpacking
    // Subnormals are folded into CLS_ZERO
    typedef enum logic [1:0] {
        CLS_ZERO   = 2'd0,
        CLS_NORMAL = 2'd1,
        CLS_INF    = 2'd2,
        CLS_NAN    = 2'd3
    } fpClassE;

    // Radix-4 Booth digit selected by one multiplier bit triplet
    typedef enum logic [2:0] {
        BD_ZERO = 3'd0,
        BD_POS1 = 3'd1,
        BD_POS2 = 3'd2,
        BD_NEG1 = 3'd3,
        BD_NEG2 = 3'd4
    } boothDigitE;

endpackage

//--- hdl/fp_operand_if.sv
`include "fp_mul_defines.svh"

// One classified operand pair on its way from stage 1 to stage 2
interface fpOperandIf import fp_mul_pkg::*; ();

    logic                 valid;
    logic                 signX;
    logic                 signY;
    logic [`FP_EXP_W-1:0] expX;
    logic [`FP_EXP_W-1:0] expY;
    fpClassE              clsX;
    fpClassE              clsY;
    roundModeE            rMode;

    modport producer (
        output valid, signX, signY, expX, expY, clsX, clsY, rMode
    );

    modport consumer (
        input valid, signX, signY, expX, expY, clsX, clsY, rMode
    );

endinterface

//--- hdl/fp_round_norm.sv
`include "fp_mul_defines.svh"

module fp_round_norm import fp_mul_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    fpOperandIf.consumer          opnd,
    input  logic [`FP_PROD_W-1:0] prodFull,
    output logic                  outValid,
    output logic [`FP_WORD_W-1:0] fpZ,
    output logic                  ovrf,
    output logic                  udrf
);

    localparam int ExpW   = `FP_EXP_W + 2;
    localparam int ExpMax = (1 << `FP_EXP_W) - 1;
    localparam int ProdTop = `FP_PROD_W - 1;

    logic                   signZ;
    logic                   isNan;
    logic                   isInf;
    logic                   isZero;
    logic                   normShift;
    logic [`FP_FRAC_W-1:0]  fracPre;
    logic                   guardBit;
    logic                   stickyBit;
    logic                   roundUp;
    logic [`FP_FRAC_W:0]    fracInc;
    logic signed [ExpW-1:0] expPre;
    logic signed [ExpW-1:0] expFinal;
    logic [`FP_FRAC_W-1:0]  fracFinal;
    logic                   ovfToInf;
    logic                   ovfNext;
    logic                   udfNext;
    logic [`FP_WORD_W-1:0]  resNext;

    assign signZ = opnd.signX ^ opnd.signY;

    always_comb begin
        isNan = (opnd.clsX == CLS_NAN) || (opnd.clsY == CLS_NAN) ||
                (opnd.clsX == CLS_INF && opnd.clsY == CLS_ZERO) ||
                (opnd.clsX == CLS_ZERO && opnd.clsY == CLS_INF);
        isInf  = (opnd.clsX == CLS_INF) || (opnd.clsY == CLS_INF);
        isZero = (opnd.clsX == CLS_ZERO) || (opnd.clsY == CLS_ZERO);
    end

    // Product of two normal significands lies in [1, 4)
    always_comb begin
        normShift = prodFull[ProdTop];
        if (normShift) begin
            fracPre   = prodFull[ProdTop-1 -: `FP_FRAC_W];
            guardBit  = prodFull[ProdTop-1-`FP_FRAC_W];
            stickyBit = |prodFull[ProdTop-2-`FP_FRAC_W:0];
        end else begin
            fracPre   = prodFull[ProdTop-2 -: `FP_FRAC_W];
            guardBit  = prodFull[ProdTop-2-`FP_FRAC_W];
            stickyBit = |prodFull[ProdTop-3-`FP_FRAC_W:0];
        end
    end

    always_comb begin
        case (opnd.rMode)
            RTZ:     roundUp = 1'b0;
            RDN:     roundUp = signZ & (guardBit | stickyBit);
            RUP:     roundUp = ~signZ & (guardBit | stickyBit);
            RMM:     roundUp = guardBit;
            default: roundUp = guardBit & (stickyBit | fracPre[0]);
        endcase
    end

    always_comb begin
        expPre  = ExpW'(opnd.expX) + ExpW'(opnd.expY) + ExpW'(normShift) - ExpW'(`FP_BIAS);
        fracInc = {1'b0, fracPre} + (`FP_FRAC_W + 1)'(roundUp);
        // Carry out of the fraction means 10.000, shift back and bump the exponent
        if (fracInc[`FP_FRAC_W]) begin
            fracFinal = '0;
            expFinal  = expPre + ExpW'(1);
        end else begin
            fracFinal = fracInc[`FP_FRAC_W-1:0];
            expFinal  = expPre;
        end
    end

    // Directed modes that point away from infinity saturate to the largest finite value
    always_comb begin
        case (opnd.rMode)
            RTZ:     ovfToInf = 1'b0;
            RDN:     ovfToInf = signZ;
            RUP:     ovfToInf = ~signZ;
            default: ovfToInf = 1'b1;
        endcase
    end

    always_comb begin
        ovfNext = 1'b0;
        udfNext = 1'b0;
        if (isNan) begin
            resNext = `FP_QNAN;
        end else if (isInf) begin
            resNext = {signZ, {`FP_EXP_W{1'b1}}, {`FP_FRAC_W{1'b0}}};
        end else if (isZero) begin
            resNext = {signZ, {(`FP_WORD_W - 1){1'b0}}};
        end else if (expFinal >= ExpMax) begin
            ovfNext = 1'b1;
            if (ovfToInf) begin
                resNext = {signZ, {`FP_EXP_W{1'b1}}, {`FP_FRAC_W{1'b0}}};
            end else begin
                resNext = {signZ, {(`FP_EXP_W - 1){1'b1}}, 1'b0, {`FP_FRAC_W{1'b1}}};
            end
        end else if (expFinal <= 0) begin
            // Tiny results flush to signed zero
            udfNext = 1'b1;
            resNext = {signZ, {(`FP_WORD_W - 1){1'b0}}};
        end else begin
            resNext = {signZ, expFinal[`FP_EXP_W-1:0], fracFinal};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
            fpZ      <= '0;
            ovrf     <= 1'b0;
            udrf     <= 1'b0;
        end else begin
            outValid <= opnd.valid;
            if (opnd.valid) begin
                fpZ  <= resNext;
                ovrf <= ovfNext;
                udrf <= udfNext;
            end
        end
    end

endmodule

//--- hdl/fp_unpack.sv
`include "fp_mul_defines.svh"

module fp_unpack import fp_mul_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inValid,
    input  logic [`FP_WORD_W-1:0] fpX,
    input  logic [`FP_WORD_W-1:0] fpY,
    input  roundModeE             rMode,
    fpOperandIf.producer          opnd
);

    localparam int SignPos = `FP_WORD_W - 1;
    localparam int ExpLsb  = `FP_FRAC_W;

    fpClassE clsXNext;
    fpClassE clsYNext;

    function automatic fpClassE classify(
        input logic [`FP_EXP_W-1:0]  expField,
        input logic [`FP_FRAC_W-1:0] fracField
    );
        fpClassE cls;
        if (expField == '0) begin
            // Flush-to-zero, subnormals count as zero
            cls = CLS_ZERO;
        end else if (&expField) begin
            cls = (fracField == '0) ? CLS_INF : CLS_NAN;
        end else begin
            cls = CLS_NORMAL;
        end
        return cls;
    endfunction

    always_comb begin
        clsXNext = classify(fpX[SignPos-1:ExpLsb], fpX[`FP_FRAC_W-1:0]);
        clsYNext = classify(fpY[SignPos-1:ExpLsb], fpY[`FP_FRAC_W-1:0]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            opnd.valid <= 1'b0;
        end else begin
            opnd.valid <= inValid;
        end
    end

    // Operand fields only move on a sampled pair
    always_ff @(posedge clk) begin
        if (inValid) begin
            opnd.signX <= fpX[SignPos];
            opnd.signY <= fpY[SignPos];
            opnd.expX  <= fpX[SignPos-1:ExpLsb];
            opnd.expY  <= fpY[SignPos-1:ExpLsb];
            opnd.clsX  <= clsXNext;
            opnd.clsY  <= clsYNext;
            opnd.rMode <= rMode;
        end
    end

endmodule

//--- verif/fp_mul_assert.sv
`include "fp_mul_defines.svh"

module fp_mul_assert import fp_mul_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic                  inValid,
    input logic [`FP_WORD_W-1:0] fpX,
    input logic [`FP_WORD_W-1:0] fpY,
    input roundModeE             rMode,
    input logic                  outValid,
    input logic [`FP_WORD_W-1:0] fpZ,
    input logic                  ovrf,
    input logic                  udrf
);

    // Pair sampled one and two rising edges ago
    logic        h1Valid;
    logic        h2Valid;
    logic [31:0] h1X;
    logic [31:0] h1Y;
    logic [31:0] h2X;
    logic [31:0] h2Y;
    logic [2:0]  h1Mode;
    logic [2:0]  h2Mode;
    // Expected {ovrf, udrf, fpZ} for the pair in h2
    logic [33:0] refRes;
    int          latErrs = 0;
    int          valErrs = 0;
    int          ovfErrs = 0;
    int          udfErrs = 0;
    int          failCount;

    function automatic logic [33:0] refMul(
        input logic [31:0] x,
        input logic [31:0] y,
        input logic [2:0]  mode
    );
        logic        sign;
        logic        zeroX;
        logic        zeroY;
        logic        infX;
        logic        infY;
        logic        nanX;
        logic        nanY;
        logic [47:0] prod;
        logic [47:0] norm;
        logic [23:0] mant;
        logic        lost;
        logic        inc;
        int          e;
        sign  = x[31] ^ y[31];
        zeroX = (x[30:23] == 8'h00);
        zeroY = (y[30:23] == 8'h00);
        infX  = (x[30:23] == 8'hFF) && (x[22:0] == 23'd0);
        infY  = (y[30:23] == 8'hFF) && (y[22:0] == 23'd0);
        nanX  = (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
        nanY  = (y[30:23] == 8'hFF) && (y[22:0] != 23'd0);
        if (nanX || nanY || (infX && zeroY) || (zeroX && infY)) begin
            return {2'b00, `FP_QNAN};
        end
        if (infX || infY) begin
            return {2'b00, sign, 8'hFF, 23'd0};
        end
        if (zeroX || zeroY) begin
            return {2'b00, sign, 31'd0};
        end
        // Plain integer multiply of the significands
        prod = {1'b1, x[22:0]} * {1'b1, y[22:0]};
        e    = int'(x[30:23]) + int'(y[30:23]) - `FP_BIAS;
        if (prod[47]) begin
            e    = e + 1;
            norm = prod;
        end else begin
            norm = prod << 1;
        end
        lost = norm[23] | (|norm[22:0]);
        case (mode)
            3'd1:    inc = 1'b0;
            3'd2:    inc = sign & lost;
            3'd3:    inc = ~sign & lost;
            3'd4:    inc = norm[23];
            default: inc = norm[23] & ((|norm[22:0]) | norm[24]);
        endcase
        mant = {1'b0, norm[46:24]} + 24'(inc);
        if (mant[23]) begin
            e = e + 1;
        end
        if (e >= 255) begin
            if (mode == 3'd1 || (mode == 3'd2 && !sign) || (mode == 3'd3 && sign)) begin
                return {2'b10, sign, 8'hFE, 23'h7FFFFF};
            end
            return {2'b10, sign, 8'hFF, 23'd0};
        end
        if (e <= 0) begin
            return {2'b01, sign, 31'd0};
        end
        return {2'b00, sign, e[7:0], mant[22:0]};
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            h1Valid <= 1'b0;
            h2Valid <= 1'b0;
        end else begin
            h1Valid <= inValid;
            h2Valid <= h1Valid;
        end
    end

    always_ff @(posedge clk) begin
        h1X    <= fpX;
        h1Y    <= fpY;
        h1Mode <= rMode;
        h2X    <= h1X;
        h2Y    <= h1Y;
        h2Mode <= h1Mode;
    end

    assign refRes    = refMul(h2X, h2Y, h2Mode);
    assign failCount = latErrs + valErrs + ovfErrs + udfErrs;

    // Result appears exactly two edges after its pair and at no other time
    latencyChk: assert property (@(posedge clk) disable iff (rst) outValid == h2Valid)
        else begin
            latErrs++;
            $error("mismatch at %0t: outValid got %b expected %b",
                   $time, $sampled(outValid), $sampled(h2Valid));
        end

    resultChk: assert property (@(posedge clk) disable iff (rst)
        outValid |-> fpZ == refRes[31:0])
        else begin
            valErrs++;
            $error("mismatch at %0t: fpZ got %h expected %h",
                   $time, $sampled(fpZ), $sampled(refRes[31:0]));
        end

    ovrfChk: assert property (@(posedge clk) disable iff (rst) outValid |-> ovrf == refRes[33])
        else begin
            ovfErrs++;
            $error("mismatch at %0t: ovrf got %b expected %b",
                   $time, $sampled(ovrf), $sampled(refRes[33]));
        end

    udrfChk: assert property (@(posedge clk) disable iff (rst) outValid |-> udrf == refRes[32])
        else begin
            udfErrs++;
            $error("mismatch at %0t: udrf got %b expected %b",
                   $time, $sampled(udrf), $sampled(refRes[32]));
        end

endmodule

bind fp_mul fp_mul_assert checker_i (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .fpX      (fpX),
    .fpY      (fpY),
    .rMode    (rMode),
    .outValid (outValid),
    .fpZ      (fpZ),
    .ovrf     (ovrf),
    .udrf     (udrf)
);

//--- verif/fp_mul_tb.sv
module fp_mul_tb import fp_mul_pkg::*; ();

    localparam int Timeout  = 20;
    localparam int BurstLen = 48;

    logic        clk;
    logic        rst;
    logic        inValid;
    logic [31:0] fpX;
    logic [31:0] fpY;
    roundModeE   rMode;
    logic        outValid;
    logic [31:0] fpZ;
    logic        ovrf;
    logic        udrf;
    int          seed;

    fp_mul fp_mul_i (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .fpX      (fpX),
        .fpY      (fpY),
        .rMode    (rMode),
        .outValid (outValid),
        .fpZ      (fpZ),
        .ovrf     (ovrf),
        .udrf     (udrf)
    );

    always #4 clk = ~clk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // Advance to the next falling edge and pick up any assertion that fired
    task automatic stepCycle();
        @(negedge clk);
        if (fp_mul_i.checker_i.failCount != 0) begin
            failRun("an assertion in fp_mul_assert failed");
        end
    endtask

    // Normal operand with an exponent that keeps most products in range
    function automatic logic [31:0] randNormal();
        logic [31:0] r;
        r = $random(seed);
        return {r[31], 8'd64 + {1'b0, r[29:23]}, r[22:0]};
    endfunction

    task automatic sendPair(input logic [31:0] x, input logic [31:0] y, input roundModeE m);
        inValid = 1'b1;
        fpX     = x;
        fpY     = y;
        rMode   = m;
        stepCycle();
        inValid = 1'b0;
    endtask

    task automatic waitResult();
        int n;
        n = 0;
        while (!outValid) begin
            if (n == Timeout) begin
                failRun("timeout: outValid never rose for the issued pair");
            end
            stepCycle();
            n++;
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (outValid) begin
            if (n == Timeout) begin
                failRun("timeout: outValid stayed high after the last pair");
            end
            stepCycle();
            n++;
        end
    endtask

    task automatic runPair(input logic [31:0] x, input logic [31:0] y, input roundModeE m);
        sendPair(x, y, m);
        waitResult();
    endtask

    initial begin
        int          i;
        int          k;
        logic [31:0] r;
        logic [31:0] x;
        logic [31:0] y;
        seed    = 53121;
        clk     = 1'b0;
        rst     = 1'b1;
        inValid = 1'b0;
        fpX     = '0;
        fpY     = '0;
        rMode   = RNE;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        // Zeros, subnormals, infinities and NaNs
        runPair(32'h00000000, 32'h3FC00000, RNE);
        runPair(32'h80000000, 32'h40490FDB, RNE);
        runPair(32'h00012345, 32'hC0000000, RNE);
        runPair(32'h3F800000, 32'h807FFFFF, RUP);
        runPair(32'h7F800000, 32'h3F800000, RNE);
        runPair(32'hFF800000, 32'h40000000, RDN);
        runPair(32'h7FC00001, 32'h3F800000, RNE);
        runPair(32'h3F800000, 32'hFF812345, RTZ);
        runPair(32'h7F800000, 32'h00000000, RNE);
        runPair(32'h80000000, 32'hFF800000, RNE);
        runPair(32'h00000001, 32'h7F800000, RMM);
        runPair(32'h7F800000, 32'hFF800000, RNE);
        runPair(32'h7FFFFFFF, 32'h00000000, RNE);

        // Normal products under every mode code, 5 to 7 included
        for (k = 0; k < 8; k++) begin
            for (i = 0; i < 12; i++) begin
                x = randNormal();
                y = randNormal();
                runPair(x, y, roundModeE'(k[2:0]));
            end
        end

        // Overflow and underflow for each mode and both signs
        for (k = 0; k < 5; k++) begin
            runPair(32'h7F000000, 32'h40000000, roundModeE'(k[2:0]));
            runPair(32'hFF7FFFFF, 32'h3FC00000, roundModeE'(k[2:0]));
            runPair(32'h7F7FFFFF, 32'hBF800001, roundModeE'(k[2:0]));
            runPair(32'h00800000, 32'h3F000000, roundModeE'(k[2:0]));
            runPair(32'h80800000, 32'h3F7FFFFF, roundModeE'(k[2:0]));
            runPair(32'h1F800000, 32'h9F800000, roundModeE'(k[2:0]));
        end

        // Back-to-back raw patterns with the odd idle cycle
        for (i = 0; i < BurstLen; i++) begin
            r = $random(seed);
            x = $random(seed);
            y = $random(seed);
            sendPair(x, y, roundModeE'(r[2:0]));
            if (r[5:3] == 3'd0) begin
                stepCycle();
            end
        end
        drain();
        stepCycle();
        stepCycle();

        if (fp_mul_i.checker_i.failCount != 0) begin
            failRun("assertion failures were recorded");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule
